// ==== Makefile ====
# Verilator build and run for the Xbus memory section.

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_xbus_memory
FILELIST = vlog.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src/xbus_io_regs.sv ====
// ******************************
// Xbus I/O register page
// ******************************

`timescale 1ns/1ns

module xbus_io_regs
   import xbus_pkg::*, xbus_map_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          bus_req,
   input  xbus_req_t     bus_cmd,
   input  logic          bus_done,
   input  logic          bus_error,
   output logic          decode,
   output logic          ack,
   output logic [31:0]   rdata
);

   io_reg_e       reg_idx;
   logic          access;
   logic [31:0]   scratch;
   logic [31:0]   xfer_count;
   logic [31:0]   error_count;

   // Page match on the upper address bits.
   assign decode  = (bus_cmd.addr[XBUS_ADDR_W-1:IO_PAGE_W] ==
                     IO_BASE[XBUS_ADDR_W-1:IO_PAGE_W]);
   assign reg_idx = io_reg_e'(bus_cmd.addr[IO_PAGE_W-1:0]);
   assign access  = bus_req & decode & ~ack;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack         <= 1'b0;
         scratch     <= '0;
         xfer_count  <= '0;
         error_count <= '0;
      end
      else
      begin
         ack <= access;
         if (access && bus_cmd.op == OP_WRITE && reg_idx == REG_SCRATCH)
            scratch <= bus_cmd.wdata;
         // Counters see every bus cycle, not only this page.
         if (bus_done && !bus_error)
            xfer_count <= xfer_count + 32'd1;
         if (bus_done && bus_error)
            error_count <= error_count + 32'd1;
      end
   end

   always_comb
   begin
      case (reg_idx)
         REG_SCRATCH:     rdata = scratch;
         REG_XFER_COUNT:  rdata = xfer_count;
         REG_ERROR_COUNT: rdata = error_count;
         default:         rdata = '0;
      endcase
   end

endmodule

// ==== src/xbus_map_pkg.sv ====
// ******************************
// Xbus address map
// ******************************

package xbus_map_pkg;

   // Word address width on the bus.
   localparam int unsigned XBUS_ADDR_W = 22;

   // First address above the decoded DRAM window.
   localparam logic [XBUS_ADDR_W-1:0] DRAM_LIMIT = 22'o11000000;

   // I/O page, 8 words.
   localparam logic [XBUS_ADDR_W-1:0] IO_BASE = 22'o17777700;
   localparam int unsigned IO_PAGE_W = 3;

   typedef enum logic [IO_PAGE_W-1:0]
   {
      REG_SCRATCH     = 3'd0,
      REG_XFER_COUNT  = 3'd1,
      REG_ERROR_COUNT = 3'd2
   } io_reg_e;

endpackage

// ==== src/xbus_memory_top.sv ====
// ******************************
// Xbus memory section
// ******************************

`timescale 1ns/1ns

module xbus_memory_top
   import xbus_pkg::*;
#(
   parameter int RAM_WORDS      = 1024,
   parameter int ACK_DELAY      = 7,
   parameter int TIMEOUT_CYCLES = 16
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        host_req,
   input  xbus_req_t   host_cmd,
   output logic        busy,
   output logic        done,
   output xbus_rsp_t   result
);

   logic          bus_req;
   xbus_req_t     bus_cmd;
   logic          bus_done;
   logic          bus_error;
   logic          ram_decode;
   logic          ram_ack;
   logic [31:0]   ram_rdata;
   logic          io_decode;
   logic          io_ack;
   logic [31:0]   io_rdata;

   xbus_request_port u_request_port
   (
      .clk      (clk),
      .reset    (reset),
      .host_req (host_req),
      .host_cmd (host_cmd),
      .bus_done (bus_done),
      .bus_req  (bus_req),
      .bus_cmd  (bus_cmd),
      .busy     (busy)
   );

   xbus_ram #(.RAM_WORDS(RAM_WORDS), .ACK_DELAY(ACK_DELAY)) u_ram
   (
      .clk     (clk),
      .reset   (reset),
      .bus_req (bus_req),
      .bus_cmd (bus_cmd),
      .decode  (ram_decode),
      .ack     (ram_ack),
      .rdata   (ram_rdata)
   );

   xbus_io_regs u_io_regs
   (
      .clk       (clk),
      .reset     (reset),
      .bus_req   (bus_req),
      .bus_cmd   (bus_cmd),
      .bus_done  (bus_done),
      .bus_error (bus_error),
      .decode    (io_decode),
      .ack       (io_ack),
      .rdata     (io_rdata)
   );

   xbus_response #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_response
   (
      .clk        (clk),
      .reset      (reset),
      .bus_req    (bus_req),
      .ram_decode (ram_decode),
      .ram_ack    (ram_ack),
      .io_decode  (io_decode),
      .io_ack     (io_ack),
      .ram_rdata  (ram_rdata),
      .io_rdata   (io_rdata),
      .bus_done   (bus_done),
      .bus_error  (bus_error),
      .done       (done),
      .result     (result)
   );

endmodule

// ==== src/xbus_pkg.sv ====
// ******************************
// Xbus transaction types
// ******************************

package xbus_pkg;

   // Bus opcode.
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } xbus_op_e;

   // ******************************
   // Request and response words.

   typedef struct packed
   {
      xbus_op_e                               op;
      logic [xbus_map_pkg::XBUS_ADDR_W-1:0]   addr;
      logic [31:0]                            wdata;
   } xbus_req_t;

   typedef struct packed
   {
      logic [31:0]   rdata;
      logic          bus_error;
   } xbus_rsp_t;

   // ******************************
   // Request port states.

   typedef enum logic
   {
      PORT_IDLE = 1'b0,
      PORT_BUSY = 1'b1
   } port_state_e;

endpackage

// ==== src/xbus_ram.sv ====
// ******************************
// Xbus RAM slave
// ******************************

`timescale 1ns/1ns

module xbus_ram
   import xbus_pkg::*, xbus_map_pkg::*;
#(
   parameter int RAM_WORDS = 1024,
   parameter int ACK_DELAY = 7
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          bus_req,
   input  xbus_req_t     bus_cmd,
   output logic          decode,
   output logic          ack,
   output logic [31:0]   rdata
);

   localparam int RAM_AW = $clog2(RAM_WORDS);

   logic [31:0]            mem [RAM_WORDS];
   logic                   req_delayed;
   logic [ACK_DELAY-1:0]   ack_chain;
   logic [RAM_AW-1:0]      ram_index;
   logic                   in_range;

   // Whole DRAM window is decoded, but only the low part is backed.
   assign decode    = (bus_cmd.addr < DRAM_LIMIT);
   assign in_range  = (bus_cmd.addr < XBUS_ADDR_W'(RAM_WORDS));
   assign ram_index = bus_cmd.addr[RAM_AW-1:0];

   // ******************************
   // Acknowledge delay.

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_delayed <= 1'b0;
         ack_chain   <= '0;
      end
      else
      begin
         // Only the first sighting starts the chain.
         req_delayed  <= bus_req & decode & ~req_delayed & ~|ack_chain;
         ack_chain[0] <= req_delayed;
         for (int i = 1; i < ACK_DELAY; i++)
         begin
            ack_chain[i] <= ack_chain[i-1];
         end
      end
   end

   assign ack = ack_chain[ACK_DELAY-1];

   // ******************************
   // Storage.

   // Write lands one cycle after the request is first seen.
   always_ff @(posedge clk)
   begin
      if (bus_req && decode && req_delayed && bus_cmd.op == OP_WRITE && in_range)
         mem[ram_index] <= bus_cmd.wdata;
   end

   // Reads above the real memory return all ones.
   assign rdata = in_range ? mem[ram_index] : '1;

endmodule

// ==== src/xbus_request_port.sv ====
// ******************************
// Xbus request port
// ******************************

`timescale 1ns/1ns

module xbus_request_port
   import xbus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        host_req,
   input  xbus_req_t   host_cmd,
   input  logic        bus_done,
   output logic        bus_req,
   output xbus_req_t   bus_cmd,
   output logic        busy
);

   port_state_e state;

   // One request at a time; requests while busy are dropped.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= PORT_IDLE;
      end
      else
      begin
         case (state)
            PORT_IDLE:
            begin
               if (host_req)
                  state <= PORT_BUSY;
            end
            PORT_BUSY:
            begin
               if (bus_done)
                  state <= PORT_IDLE;
            end
            default:
            begin
               state <= PORT_IDLE;
            end
         endcase
      end
   end

   // Command is held for the whole bus cycle.
   always_ff @(posedge clk)
   begin
      if (state == PORT_IDLE && host_req)
         bus_cmd <= host_cmd;
   end

   assign bus_req = (state == PORT_BUSY);
   assign busy    = bus_req;

endmodule

// ==== src/xbus_response.sv ====
// ******************************
// Xbus response and watchdog
// ******************************

`timescale 1ns/1ns

module xbus_response
   import xbus_pkg::*;
#(
   parameter int TIMEOUT_CYCLES = 16
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          bus_req,
   input  logic          ram_decode,
   input  logic          ram_ack,
   input  logic          io_decode,
   input  logic          io_ack,
   input  logic [31:0]   ram_rdata,
   input  logic [31:0]   io_rdata,
   output logic          bus_done,
   output logic          bus_error,
   output logic          done,
   output xbus_rsp_t     result
);

   localparam int WD_W = $clog2(TIMEOUT_CYCLES + 1);

   logic [WD_W-1:0]   wd_count;
   logic              no_decode;
   logic              wd_expire;
   logic [31:0]       merged_rdata;

   // ******************************
   // Watchdog for undecoded addresses.

   assign no_decode = ~ram_decode & ~io_decode;

   always_ff @(posedge clk)
   begin
      if (reset || !bus_req || bus_done)
         wd_count <= '0;
      else if (no_decode)
         wd_count <= wd_count + 1'b1;
   end

   assign wd_expire = bus_req & no_decode & (wd_count == WD_W'(TIMEOUT_CYCLES));

   // ******************************
   // Merge and register.

   assign bus_done  = ram_ack | io_ack | wd_expire;
   assign bus_error = wd_expire;

   // Timeout falls through to all ones.
   assign merged_rdata = ram_ack ? ram_rdata :
                         io_ack  ? io_rdata  : '1;

   always_ff @(posedge clk)
   begin
      if (reset)
         done <= 1'b0;
      else
         done <= bus_done;
   end

   always_ff @(posedge clk)
   begin
      if (bus_done)
         result <= '{rdata: merged_rdata, bus_error: bus_error};
   end

endmodule

// ==== test/tb_xbus_memory.sv ====
// ******************************
// Xbus memory testbench
// ******************************

`timescale 1ns/1ns

module tb_xbus_memory
   import xbus_pkg::*, xbus_map_pkg::*;
();

   localparam int RAM_WORDS      = 64;
   localparam int ACK_DELAY      = 7;
   localparam int TIMEOUT_CYCLES = 16;
   localparam int RAM_AW         = $clog2(RAM_WORDS);
   localparam int DONE_LIMIT     = TIMEOUT_CYCLES + ACK_DELAY + 8;
   localparam int TRANSACTIONS   = 64;
   localparam int CYCLE_LIMIT    = 16 + TRANSACTIONS * DONE_LIMIT;

   logic        clk = 1'b0;
   logic        reset;
   logic        host_req;
   xbus_req_t   host_cmd;
   logic        busy;
   logic        done;
   xbus_rsp_t   result;

   logic [31:0]   model_mem [RAM_WORDS];
   logic [31:0]   lcg_state;
   int            cycle_count = 0;
   int            error_total = 0;
   int            check_total = 0;
   int            xfers_seen = 0;
   int            bus_errors_seen = 0;

   xbus_memory_top #(
      .RAM_WORDS      (RAM_WORDS),
      .ACK_DELAY      (ACK_DELAY),
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) uut
   (
      .clk      (clk),
      .reset    (reset),
      .host_req (host_req),
      .host_cmd (host_cmd),
      .busy     (busy),
      .done     (done),
      .result   (result)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("Run stopped: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Neither the DRAM window nor the 8-word I/O page.
   function automatic logic is_undecoded(input logic [21:0] addr);
      logic in_io;
      in_io = (addr >= IO_BASE) && (addr < IO_BASE + 22'd8);
      return (addr >= DRAM_LIMIT) && !in_io;
   endfunction

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      check_total++;
      assert (got == exp)
      else
      begin
         error_total++;
         $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      check_total++;
      assert (got == exp)
      else
      begin
         error_total++;
         $display("[ERROR] %0t ns: %s got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic start_request(input xbus_op_e op, input logic [21:0] addr,
                                input logic [31:0] wdata);
      @(posedge clk);
      host_req <= 1'b1;
      host_cmd <= '{op: op, addr: addr, wdata: wdata};
      @(posedge clk);
      host_req <= 1'b0;
   endtask

   // One bus cycle, waiting for done with a limit.
   task automatic bus_transfer(input xbus_op_e op, input logic [21:0] addr,
                               input logic [31:0] wdata, output xbus_rsp_t rsp);
      int waited;
      waited = 0;
      start_request(op, addr, wdata);
      @(negedge clk);
      while (!done && waited < DONE_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!done)
      begin
         error_total++;
         $display("No done within %0d cycles for address %o", DONE_LIMIT, addr);
      end
      rsp = result;
      if (is_undecoded(addr))
         bus_errors_seen++;
      else
         xfers_seen++;
   endtask

   task automatic write_word(input logic [21:0] addr, input logic [31:0] data);
      xbus_rsp_t rsp;
      bus_transfer(OP_WRITE, addr, data, rsp);
      check_flag("write bus_error", rsp.bus_error, is_undecoded(addr));
      if (addr < 22'(RAM_WORDS))
         model_mem[addr[RAM_AW-1:0]] = data;
   endtask

   task automatic read_expect(input string what, input logic [21:0] addr,
                              input logic [31:0] exp_data, input logic exp_err);
      xbus_rsp_t rsp;
      bus_transfer(OP_READ, addr, 32'd0, rsp);
      check_word(what, rsp.rdata, exp_data);
      check_flag({what, " bus_error"}, rsp.bus_error, exp_err);
   endtask

   // ******************************
   // Directed tests.

   task automatic ram_write_readback();
      logic [21:0] addr;
      logic [31:0] data;
      check_flag("busy after reset", busy, 1'b0);
      check_flag("done after reset", done, 1'b0);
      for (int i = 0; i < 20; i++)
      begin
         addr = 22'((lcg_next() >> 8) % RAM_WORDS);
         data = lcg_next();
         write_word(addr, data);
         read_expect("RAM readback", addr, model_mem[addr[RAM_AW-1:0]], 1'b0);
      end
   endtask

   task automatic dram_window_alias();
      logic [21:0] low;
      logic [21:0] high;
      low  = 22'((lcg_next() >> 8) % RAM_WORDS);
      high = 22'(((lcg_next() >> 8) % 30000 + 1) * RAM_WORDS) + low;
      write_word(low, lcg_next());
      read_expect("window top read", DRAM_LIMIT - 22'd1, 32'hFFFF_FFFF, 1'b0);
      read_expect("window read", high, 32'hFFFF_FFFF, 1'b0);
      write_word(high, lcg_next());
      read_expect("RAM word under window write", low, model_mem[low[RAM_AW-1:0]], 1'b0);
   endtask

   task automatic io_page_registers();
      logic [31:0] value;
      value = lcg_next();
      write_word(IO_BASE + 22'(REG_SCRATCH), value);
      read_expect("scratch register", IO_BASE + 22'(REG_SCRATCH), value, 1'b0);
      write_word(IO_BASE + 22'(REG_XFER_COUNT), ~value);
      read_expect("transfer count", IO_BASE + 22'(REG_XFER_COUNT), 32'(xfers_seen), 1'b0);
   endtask

   task automatic undecoded_bus_error();
      read_expect("undecoded read", DRAM_LIMIT + 22'((lcg_next() >> 8) % 1000),
                  32'hFFFF_FFFF, 1'b1);
      read_expect("read below I/O page", IO_BASE - 22'd1, 32'hFFFF_FFFF, 1'b1);
      read_expect("error count", IO_BASE + 22'(REG_ERROR_COUNT), 32'(bus_errors_seen), 1'b0);
   endtask

   task automatic busy_request_drop();
      logic [21:0] first_addr;
      logic [21:0] second_addr;
      logic [31:0] first_data;
      logic [31:0] kept_data;
      int dones;
      first_addr  = 22'((lcg_next() >> 8) % RAM_WORDS);
      second_addr = 22'((first_addr + 1) % RAM_WORDS);
      kept_data   = lcg_next();
      first_data  = lcg_next();
      write_word(second_addr, kept_data);
      start_request(OP_WRITE, first_addr, first_data);
      @(negedge clk);
      check_flag("busy during request", busy, 1'b1);
      // This one arrives while busy and must be dropped.
      start_request(OP_WRITE, second_addr, ~kept_data);
      dones = 0;
      repeat (DONE_LIMIT)
      begin
         @(negedge clk);
         if (done)
            dones++;
      end
      model_mem[first_addr[RAM_AW-1:0]] = first_data;
      xfers_seen++;
      check_word("done pulses", 32'(dones), 32'd1);
      read_expect("word of dropped request", second_addr, kept_data, 1'b0);
      read_expect("word of accepted request", first_addr, first_data, 1'b0);
   endtask

   initial
   begin
      lcg_state = 32'd28;
      reset     = 1'b1;
      host_req  = 1'b0;
      host_cmd  = '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      ram_write_readback();
      dram_window_alias();
      io_page_registers();
      undecoded_bus_error();
      busy_request_drop();
      $display("Checks: %0d, errors: %0d", check_total, error_total);
      if (error_total == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== vlog.f ====
src/xbus_map_pkg.sv
src/xbus_pkg.sv
src/xbus_request_port.sv
src/xbus_ram.sv
src/xbus_io_regs.sv
src/xbus_response.sv
src/xbus_memory_top.sv
test/tb_xbus_memory.sv
